//--- Makefile
SIM = obj_dir/Vbitser_tb

.PHONY: run clean

run: $(SIM)
	./$(SIM)

# rebuilt only when the file list or one of the sources it names changes
$(SIM): bitser.f $(shell cat bitser.f)
	verilator --binary --timing --assert -j 0 --top-module bitser_tb -f bitser.f

clean:
	rm -rf obj_dir

//--- bitser.f
source/bitser_pkg.sv
source/bitser_state.sv
source/bitser_decode.sv
source/bitser_alu.sv
source/bitser_rf.sv
source/bitser_ctrl.sv
source/bitser_top.sv
verif/bitser_tb.sv

//--- source/bitser_alu.sv
module bitser_alu
   import bitser_pkg::*;
(
   input  logic i_clk,
   input  cnt_t i_cnt,
   input  dec_t i_dec,
   input  logic i_rs1_bit,
   input  logic i_rs2_bit,
   input  logic i_imm_bit,
   input  logic i_pc_bit,
   output logic o_rd_bit,
   output logic o_cmp
);

   logic op_b;
   logic op_b_inv;
   logic carry_r;
   logic carry_in;
   logic sum_bit;
   logic carry_out;
   logic eq_r;
   logic eq_now;
   logic lt_now;
   logic tgt_carry_r;
   logic tgt_carry_in;
   logic tgt_bit;
   logic cmp_r;
   logic result_bit;

   assign op_b = i_dec.use_imm ? i_imm_bit : i_rs2_bit;
   // a - b is a + ~b + 1 so sub inverts b and seeds the carry at bit 0
   assign op_b_inv = op_b ^ i_dec.sub;
   assign carry_in = i_cnt.cnt0 ? i_dec.sub : carry_r;
   assign sum_bit = i_rs1_bit ^ op_b_inv ^ carry_in;
   assign carry_out = (i_rs1_bit & op_b_inv) | (i_rs1_bit & carry_in) | (op_b_inv & carry_in);

   // equality stays set only while every bit so far has matched
   assign eq_now = (i_cnt.cnt0 | eq_r) & ~(i_rs1_bit ^ op_b);
   // differing sign bits decide alone, otherwise the difference sign does
   assign lt_now = (i_rs1_bit ^ op_b) ? (i_dec.cmp_unsigned ? op_b : i_rs1_bit) : sum_bit;
   assign o_cmp = i_cnt.cnt_done & (i_dec.cmp_eq ? eq_now : lt_now);

   // second adder for pc + imm, used as jump target in stage one
   assign tgt_carry_in = ~i_cnt.cnt0 & tgt_carry_r;
   assign tgt_bit = i_pc_bit ^ i_imm_bit ^ tgt_carry_in;

   always_comb begin
      case (i_dec.alu_op)
         ALU_XOR: result_bit = i_rs1_bit ^ op_b;
         ALU_OR:  result_bit = i_rs1_bit | op_b;
         ALU_AND: result_bit = i_rs1_bit & op_b;
         default: result_bit = sum_bit;
      endcase
   end

   always_comb begin
      if (i_cnt.init) begin
         o_rd_bit = tgt_bit;
      end else if (i_dec.jal) begin
         // in the final stage the PC block already sends pc + 4
         o_rd_bit = i_pc_bit;
      end else if (i_dec.slt_op) begin
         // SLT writes the stage one result as bit 0 and zeros above
         o_rd_bit = i_cnt.cnt0 & cmp_r;
      end else begin
         o_rd_bit = result_bit;
      end
   end

   always_ff @(posedge i_clk) begin
      if (i_cnt.cnt_en) begin
         carry_r <= carry_out;
         eq_r <= eq_now;
         tgt_carry_r <= (i_pc_bit & i_imm_bit) | (i_pc_bit & tgt_carry_in) |
                        (i_imm_bit & tgt_carry_in);
      end
      // hold the compare so stage two of SLT can write it
      if (i_cnt.cnt_done) begin
         cmp_r <= o_cmp;
      end
   end

endmodule

//--- source/bitser_ctrl.sv
module bitser_ctrl
   import bitser_pkg::*;
(
   input  logic i_clk,
   input  logic i_rst,
   input  cnt_t i_cnt,
   input  logic i_alu_rd_bit,
   output logic o_pc_bit,
   output logic [XLEN-1:0] o_ibus_adr
);

   logic [XLEN-1:0] pc_sr;
   // jump target collected during stage one
   logic [XLEN-1:0] buf_r;
   // delayed cnt0 marks bit 2, where the constant four adds its one
   logic [1:0] four_dly;
   logic inc_add;
   logic inc_carry_r;
   logic inc_carry_in;
   logic plus4_bit;
   logic next_bit;

   assign inc_add = four_dly[1];
   assign inc_carry_in = ~i_cnt.cnt0 & inc_carry_r;
   assign plus4_bit = pc_sr[0] ^ inc_add ^ inc_carry_in;

   // taken jumps reload from the buffer, everything else steps by four
   assign next_bit = i_cnt.jump ? buf_r[0] : plus4_bit;

   // stage one needs the plain PC for the target adder
   // and the final stage sends pc + 4 as the JAL link value
   assign o_pc_bit = i_cnt.pc_en ? plus4_bit : pc_sr[0];

   // the PC only moves while counting, so it is stable during fetch
   assign o_ibus_adr = pc_sr;

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         pc_sr <= RESET_PC;
         four_dly <= '0;
         inc_carry_r <= 1'b0;
      end else begin
         four_dly <= {four_dly[0], i_cnt.cnt0};
         if (i_cnt.pc_en) begin
            pc_sr <= {next_bit, pc_sr[XLEN-1:1]};
            inc_carry_r <= (pc_sr[0] & inc_add) | (pc_sr[0] & inc_carry_in) |
                           (inc_add & inc_carry_in);
         end else if (i_cnt.cnt_en) begin
            // stage one rotates the PC so it is back in place afterwards
            pc_sr <= {pc_sr[0], pc_sr[XLEN-1:1]};
         end
      end
   end

   always_ff @(posedge i_clk) begin
      if (i_cnt.cnt_en & i_cnt.init) begin
         buf_r <= {i_alu_rd_bit, buf_r[XLEN-1:1]};
      end else if (i_cnt.pc_en) begin
         buf_r <= {1'b0, buf_r[XLEN-1:1]};
      end
   end

endmodule

//--- source/bitser_decode.sv
module bitser_decode
   import bitser_pkg::*;
(
   input  logic i_clk,
   input  logic i_rst,
   input  logic i_ibus_ack,
   input  logic [XLEN-1:0] i_ibus_rdt,
   input  cnt_t i_cnt,
   output dec_t o_dec,
   output logic o_imm_bit
);

   logic [XLEN-1:0] ir;
   logic [6:0] opcode;
   logic [2:0] funct3;
   logic [6:0] funct7;
   logic arith_f3;
   logic arith_valid;
   logic [XLEN-1:0] imm_word;
   logic [XLEN-1:0] imm_sr;

   assign opcode = ir[6:0];
   assign funct3 = ir[14:12];
   assign funct7 = ir[31:25];
   // shifts use funct3 001 and 101 and are not implemented
   assign arith_f3 = (funct3 != 3'b001) & (funct3 != 3'b101);

   always_comb begin
      o_dec = '0;
      o_dec.rd = ir[11:7];
      o_dec.rs1 = ir[19:15];
      o_dec.rs2 = ir[24:20];
      o_dec.alu_op = ALU_ADD;
      arith_valid = 1'b0;
      imm_word = '0;
      case (opcode)
         OPC_OP_IMM: begin
            imm_word = {{20{ir[31]}}, ir[31:20]};
            o_dec.use_imm = 1'b1;
            arith_valid = arith_f3;
         end
         OPC_OP: begin
            // only SUB may carry a nonzero funct7
            arith_valid = arith_f3 &
                          ((funct7 == 7'b0) | ((funct7 == 7'b0100000) & (funct3 == 3'b000)));
         end
         OPC_BRANCH: begin
            // funct3 010 and 011 are not branches
            if (funct3[2:1] != 2'b01) begin
               imm_word = {{19{ir[31]}}, ir[31], ir[7], ir[30:25], ir[11:8], 1'b0};
               o_dec.branch_op = 1'b1;
               o_dec.cond_branch = 1'b1;
               o_dec.sub = 1'b1;
               o_dec.bne_or_bge = funct3[0];
               o_dec.cmp_unsigned = funct3[1];
               o_dec.cmp_eq = ~funct3[2];
            end
         end
         OPC_JAL: begin
            imm_word = {{11{ir[31]}}, ir[31], ir[19:12], ir[20], ir[30:21], 1'b0};
            o_dec.branch_op = 1'b1;
            o_dec.jal = 1'b1;
            o_dec.rd_op = 1'b1;
         end
         default: begin
            // unknown encodings fall through as no-ops that write nothing
            o_dec.rd_op = 1'b0;
         end
      endcase
      if (arith_valid) begin
         o_dec.rd_op = 1'b1;
         o_dec.slt_op = (funct3[2:1] == 2'b01);
         // SLT and SLTU compare by subtracting
         o_dec.sub = o_dec.slt_op | ((opcode == OPC_OP) & funct7[5]);
         o_dec.cmp_unsigned = funct3[0];
         case (funct3)
            3'b100: o_dec.alu_op = ALU_XOR;
            3'b110: o_dec.alu_op = ALU_OR;
            3'b111: o_dec.alu_op = ALU_AND;
            default: o_dec.alu_op = ALU_ADD;
         endcase
      end
   end

   // the instruction word stays until the next acknowledge
   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         ir <= '0;
      end else if (i_ibus_ack) begin
         ir <= i_ibus_rdt;
      end
   end

   // reload while idle, then shift right with the sign bit replicated
   always_ff @(posedge i_clk) begin
      if (i_cnt.cnt_en) begin
         imm_sr <= {imm_sr[XLEN-1], imm_sr[XLEN-1:1]};
      end else begin
         imm_sr <= imm_word;
      end
   end

   assign o_imm_bit = imm_sr[0];

endmodule

//--- source/bitser_pkg.sv
package bitser_pkg;

   // data path and address width of the core
   localparam int XLEN = 32;
   // register file address width
   localparam int REG_AW = 5;
   // address of the very first fetch after reset
   localparam logic [XLEN-1:0] RESET_PC = '0;

   // major opcodes that the slice understands, everything else is a no-op
   localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
   localparam logic [6:0] OPC_OP = 7'b0110011;
   localparam logic [6:0] OPC_BRANCH = 7'b1100011;
   localparam logic [6:0] OPC_JAL = 7'b1101111;

   // result selection of the single-stage ALU operations
   typedef enum logic [1:0] {
      ALU_ADD,
      ALU_XOR,
      ALU_OR,
      ALU_AND
   } alu_op_e;

   // decoded instruction, stable from the cycle after the fetch acknowledge
   typedef struct packed {
      logic [REG_AW-1:0] rd;
      logic [REG_AW-1:0] rs1;
      logic [REG_AW-1:0] rs2;
      alu_op_e alu_op;
      // second operand is inverted and carry-in forced to one
      logic sub;
      logic use_imm;
      logic slt_op;
      // set for the conditional branches and for JAL
      logic branch_op;
      logic cond_branch;
      logic bne_or_bge;
      logic cmp_unsigned;
      // compare for equality instead of less-than
      logic cmp_eq;
      logic jal;
      logic rd_op;
   } dec_t;

   // counter and stage strobes shared by all serial blocks
   typedef struct packed {
      logic cnt_en;
      logic cnt0;
      logic cnt_done;
      logic init;
      logic pc_en;
      logic jump;
      logic stage_two;
   } cnt_t;

   // one retired register write
   typedef struct packed {
      logic [REG_AW-1:0] rd;
      logic [XLEN-1:0] data;
   } wb_t;

endpackage

//--- source/bitser_rf.sv
module bitser_rf
   import bitser_pkg::*;
(
   input  logic i_clk,
   input  logic i_rst,
   input  logic i_rreq,
   input  logic i_wreq,
   input  dec_t i_dec,
   input  cnt_t i_cnt,
   input  logic i_wr_bit,
   output logic o_ready,
   output logic o_rs1_bit,
   output logic o_rs2_bit,
   output logic o_wb_valid,
   output wb_t  o_wb
);

   logic [XLEN-1:0] regs [0:(1 << REG_AW)-1];
   logic [XLEN-1:0] rs1_sr;
   logic [XLEN-1:0] rs2_sr;
   logic [XLEN-1:0] wr_sr;
   logic [XLEN-1:0] wr_word;
   logic collect;
   logic commit;

   // only the final stage of an instruction produces rd bits
   assign collect = i_cnt.cnt_en & i_cnt.pc_en;
   // the last bit arrives together with cnt_done and is merged here
   assign wr_word = {i_wr_bit, wr_sr[XLEN-1:1]};
   // x0 is never written and never reported
   assign commit = i_cnt.cnt_done & i_cnt.pc_en & i_dec.rd_op & (i_dec.rd != '0);

   assign o_rs1_bit = rs1_sr[0];
   assign o_rs2_bit = rs2_sr[0];

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         o_ready <= 1'b0;
         o_wb_valid <= 1'b0;
      end else begin
         // every request is answered in the next cycle
         o_ready <= i_rreq | i_wreq;
         o_wb_valid <= commit;
      end
   end

   always_ff @(posedge i_clk) begin
      // operands are read while ready is high so the decode struct is current
      if (o_ready) begin
         rs1_sr <= (i_dec.rs1 == '0) ? '0 : regs[i_dec.rs1];
         rs2_sr <= (i_dec.rs2 == '0) ? '0 : regs[i_dec.rs2];
      end else if (i_cnt.cnt_en) begin
         rs1_sr <= {1'b0, rs1_sr[XLEN-1:1]};
         rs2_sr <= {1'b0, rs2_sr[XLEN-1:1]};
      end
   end

   always_ff @(posedge i_clk) begin
      // write bits enter at the top and move down to bit 0
      if (collect) begin
         wr_sr <= wr_word;
      end
      if (commit) begin
         regs[i_dec.rd] <= wr_word;
         o_wb.rd <= i_dec.rd;
         o_wb.data <= wr_word;
      end
   end

   // a new access may only start once the counter has stopped
   a_no_request_while_counting : assert property (
      @(posedge i_clk) disable iff (i_rst) (i_rreq || i_wreq) |-> !i_cnt.cnt_en);

endmodule

//--- source/bitser_state.sv
module bitser_state
   import bitser_pkg::*;
(
   input  logic i_clk,
   input  logic i_rst,
   input  logic i_ibus_ack,
   input  dec_t i_dec,
   input  logic i_rf_ready,
   input  logic i_alu_cmp,
   output logic o_ibus_cyc,
   output logic o_rf_rreq,
   output logic o_rf_wreq,
   output cnt_t o_cnt
);

   // upper three bits of the bit index
   logic [2:0] cnt_hi;
   // one-hot ring standing in for the two low bits of the index
   logic [3:0] cnt_r;
   logic cnt_en;
   logic cnt0;
   logic cnt_done;
   logic init;
   logic init_done;
   logic pc_en;
   logic jump;
   logic stage_two;
   logic ibus_cyc;
   logic two_stage_op;
   logic take_branch;

   // the counter runs whenever a one circulates in the ring
   assign cnt_en = |cnt_r;
   assign cnt0 = (cnt_hi == 3'd0) & cnt_r[0];

   // branches and JAL need a target first, SLT needs the compare result first
   assign two_stage_op = i_dec.slt_op | i_dec.branch_op;
   assign init = two_stage_op & ~init_done;

   // the PC moves only in the last stage of an instruction
   assign pc_en = cnt_en & ~init;

   // conditional branches are taken when the compare disagrees with bne/bge
   // and JAL is always taken
   assign take_branch = i_dec.branch_op &
                        (~i_dec.cond_branch | (i_alu_cmp ^ i_dec.bne_or_bge));

   // a new instruction word means the operands can be read right away
   assign o_rf_rreq = i_ibus_ack;
   // stage two starts with a second register file access
   assign o_rf_wreq = stage_two;
   assign o_ibus_cyc = ibus_cyc;

   always_comb begin
      o_cnt.cnt_en = cnt_en;
      o_cnt.cnt0 = cnt0;
      o_cnt.cnt_done = cnt_done;
      o_cnt.init = init;
      o_cnt.pc_en = pc_en;
      o_cnt.jump = jump;
      o_cnt.stage_two = stage_two;
   end

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         cnt_hi <= '0;
         cnt_r <= '0;
         cnt_done <= 1'b0;
         init_done <= 1'b0;
         jump <= 1'b0;
         stage_two <= 1'b0;
         // the first fetch is issued straight out of reset
         ibus_cyc <= 1'b1;
      end else begin
         // the high part steps each time the ring wraps through bit 3
         cnt_hi <= cnt_hi + {2'b00, cnt_r[3]};
         // rf_ready seeds the ring and cnt_done keeps it from wrapping again
         cnt_r <= {cnt_r[2:0], (cnt_r[3] & ~cnt_done) | (i_rf_ready & ~cnt_en)};
         // registered one cycle early so it lines up with bit 31
         cnt_done <= (cnt_hi == 3'd7) & cnt_r[2];

         // strobe for the idle cycle between the two stages
         stage_two <= cnt_done & init;

         // the branch decision is only valid at the end of stage one
         if (cnt_done) begin
            init_done <= init;
            jump <= init & take_branch;
         end

         // fetch ends on acknowledge and rearms once the PC is updated
         if (i_ibus_ack | cnt_done) begin
            ibus_cyc <= pc_en;
         end
      end
   end

   // the fetch bus must be idle whenever the data path is counting
   a_no_fetch_while_counting : assert property (
      @(posedge i_clk) disable iff (i_rst) !(o_ibus_cyc && cnt_en));

   // a read and a stage-two request never collide
   a_single_rf_request : assert property (
      @(posedge i_clk) disable iff (i_rst) !(o_rf_rreq && o_rf_wreq));

endmodule

//--- source/bitser_top.sv
module bitser_top
   import bitser_pkg::*;
(
   input  logic i_clk,
   input  logic i_rst,
   output logic o_ibus_cyc,
   output logic [XLEN-1:0] o_ibus_adr,
   input  logic i_ibus_ack,
   input  logic [XLEN-1:0] i_ibus_rdt,
   output logic o_wb_valid,
   output wb_t  o_wb
);

   dec_t dec;
   cnt_t cnt;
   logic rf_rreq;
   logic rf_wreq;
   logic rf_ready;
   logic alu_cmp;
   logic rs1_bit;
   logic rs2_bit;
   logic imm_bit;
   logic rd_bit;
   logic pc_bit;

   bitser_state u_state (
      .i_clk      (i_clk),
      .i_rst      (i_rst),
      .i_ibus_ack (i_ibus_ack),
      .i_dec      (dec),
      .i_rf_ready (rf_ready),
      .i_alu_cmp  (alu_cmp),
      .o_ibus_cyc (o_ibus_cyc),
      .o_rf_rreq  (rf_rreq),
      .o_rf_wreq  (rf_wreq),
      .o_cnt      (cnt)
   );

   bitser_decode u_decode (
      .i_clk      (i_clk),
      .i_rst      (i_rst),
      .i_ibus_ack (i_ibus_ack),
      .i_ibus_rdt (i_ibus_rdt),
      .i_cnt      (cnt),
      .o_dec      (dec),
      .o_imm_bit  (imm_bit)
   );

   bitser_alu u_alu (
      .i_clk     (i_clk),
      .i_cnt     (cnt),
      .i_dec     (dec),
      .i_rs1_bit (rs1_bit),
      .i_rs2_bit (rs2_bit),
      .i_imm_bit (imm_bit),
      .i_pc_bit  (pc_bit),
      .o_rd_bit  (rd_bit),
      .o_cmp     (alu_cmp)
   );

   // the ALU output carries the result, the SLT bit or the JAL link value
   bitser_rf u_rf (
      .i_clk      (i_clk),
      .i_rst      (i_rst),
      .i_rreq     (rf_rreq),
      .i_wreq     (rf_wreq),
      .i_dec      (dec),
      .i_cnt      (cnt),
      .i_wr_bit   (rd_bit),
      .o_ready    (rf_ready),
      .o_rs1_bit  (rs1_bit),
      .o_rs2_bit  (rs2_bit),
      .o_wb_valid (o_wb_valid),
      .o_wb       (o_wb)
   );

   bitser_ctrl u_ctrl (
      .i_clk        (i_clk),
      .i_rst        (i_rst),
      .i_cnt        (cnt),
      .i_alu_rd_bit (rd_bit),
      .o_pc_bit     (pc_bit),
      .o_ibus_adr   (o_ibus_adr)
   );

endmodule

//--- verif/bitser_tb.sv
module bitser_tb
   import bitser_pkg::*;
();
   timeunit 1ns;
   timeprecision 100ps;

   // 31 register inits, 8 directed instructions, random body and the closing jump
   localparam int PROG_LEN = 160;
   localparam int HALT_IDX = PROG_LEN - 1;
   localparam int WAIT_LIMIT = 300;

   // expected outcome of one instruction
   typedef struct packed {
      logic wr;
      wb_t wb;
      logic [XLEN-1:0] next_pc;
   } ref_t;

   logic i_clk;
   logic i_rst;
   logic i_ibus_ack;
   logic [XLEN-1:0] i_ibus_rdt;
   logic o_ibus_cyc;
   logic [XLEN-1:0] o_ibus_adr;
   logic o_wb_valid;
   wb_t o_wb;

   logic [XLEN-1:0] prog_mem [0:255];
   logic [XLEN-1:0] model_regs [0:31];
   logic [31:0] lcg_state;
   // fetch addresses in the order they were acknowledged
   logic [XLEN-1:0] fetch_q [$];
   // writeback records in the order the DUT issued them
   wb_t wb_q [$];

   bitser_top i_dut (
      .i_clk      (i_clk),
      .i_rst      (i_rst),
      .o_ibus_cyc (o_ibus_cyc),
      .o_ibus_adr (o_ibus_adr),
      .i_ibus_ack (i_ibus_ack),
      .i_ibus_rdt (i_ibus_rdt),
      .o_wb_valid (o_wb_valid),
      .o_wb       (o_wb)
   );

   initial begin
      i_clk = 1'b0;
      forever #2 i_clk = ~i_clk;
   end

   // two LCG steps give one word built from the better upper halves
   function automatic logic [31:0] next_rand();
      logic [15:0] hi;
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      hi = lcg_state[31:16];
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return {hi, lcg_state[31:16]};
   endfunction

   function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3,
                                         input logic [4:0] rd, input logic [6:0] opc);
      return {f7, rs2, rs1, f3, rd, opc};
   endfunction

   function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd,
                                         input logic [6:0] opc);
      return {imm, rs1, f3, rd, opc};
   endfunction

   // B format scatters the offset bits around the register fields
   function automatic logic [31:0] enc_b(input logic [12:0] off, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3);
      return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OPC_BRANCH};
   endfunction

   function automatic logic [31:0] enc_j(input logic [20:0] off, input logic [4:0] rd);
      return {off[20], off[10:1], off[11], off[19:12], rd, OPC_JAL};
   endfunction

   // BEQ, BNE, BLT, BGE, BLTU and BGEU with two codes doubled up
   function automatic logic [2:0] pick_branch_f3(input logic [2:0] sel);
      case (sel)
         3'd0: return 3'b000;
         3'd1: return 3'b001;
         3'd2: return 3'b100;
         3'd3: return 3'b101;
         3'd4: return 3'b110;
         3'd5: return 3'b111;
         3'd6: return 3'b100;
         default: return 3'b111;
      endcase
   endfunction

   // jumps only go forward so that every path reaches the closing jump
   function automatic logic [31:0] random_instr(input int idx);
      logic [31:0] r;
      logic [31:0] s;
      logic [4:0] rd;
      logic [4:0] rs1;
      logic [4:0] rs2;
      logic [2:0] f3;
      int skip;
      r = next_rand();
      s = next_rand();
      rd = r[4:0];
      rs1 = r[9:5];
      rs2 = r[14:10];
      case (s[13:12])
         2'd0: f3 = 3'b000;
         2'd1: f3 = 3'b100;
         2'd2: f3 = 3'b110;
         default: f3 = 3'b111;
      endcase
      skip = 1 + int'(s[23:22]);
      if (idx + skip > HALT_IDX) begin
         skip = HALT_IDX - idx;
      end
      case (r[17:15])
         3'd0, 3'd1: return enc_r((f3 == 3'b000 && s[20]) ? 7'h20 : 7'h00,
                                  rs2, rs1, f3, rd, OPC_OP);
         3'd2: return enc_i(s[11:0], rs1, f3, rd, OPC_OP_IMM);
         3'd3: return enc_r(7'h00, rs2, rs1, {2'b01, s[20]}, rd, OPC_OP);
         3'd4: return enc_i(s[11:0], rs1, {2'b01, s[20]}, rd, OPC_OP_IMM);
         3'd5, 3'd6: begin
            // equal operands now and then so BEQ and BGE see the equal case
            if (s[21]) begin
               rs2 = rs1;
            end
            return enc_b(13'(skip * 4), rs2, rs1, pick_branch_f3(s[26:24]));
         end
         default: return enc_j(21'(skip * 4), rd);
      endcase
   endfunction

   task automatic build_program();
      logic [31:0] w;
      // every register starts with a random signed 12-bit value
      for (int r = 1; r < 32; r++) begin
         w = next_rand();
         prog_mem[8'(r - 1)] = enc_i(w[11:0], 5'd0, 3'b000, 5'(r), OPC_OP_IMM);
      end
      // opposite signs on SLT and SLTU, then a write to x0 and a read of it
      prog_mem[31] = enc_i(12'hffd, 5'd0, 3'b000, 5'd1, OPC_OP_IMM);
      prog_mem[32] = enc_i(12'h003, 5'd0, 3'b000, 5'd2, OPC_OP_IMM);
      prog_mem[33] = enc_r(7'h00, 5'd2, 5'd1, 3'b010, 5'd3, OPC_OP);
      prog_mem[34] = enc_r(7'h00, 5'd2, 5'd1, 3'b011, 5'd4, OPC_OP);
      prog_mem[35] = enc_r(7'h00, 5'd1, 5'd2, 3'b010, 5'd5, OPC_OP);
      prog_mem[36] = enc_r(7'h00, 5'd1, 5'd2, 3'b011, 5'd6, OPC_OP);
      prog_mem[37] = enc_r(7'h00, 5'd2, 5'd1, 3'b000, 5'd0, OPC_OP);
      prog_mem[38] = enc_r(7'h20, 5'd1, 5'd0, 3'b000, 5'd7, OPC_OP);
      for (int i = 39; i < HALT_IDX; i++) begin
         prog_mem[8'(i)] = random_instr(i);
      end
      // the program parks in a jump to itself
      prog_mem[8'(HALT_IDX)] = enc_j(21'd0, 5'd0);
   endtask

   function automatic logic [XLEN-1:0] alu_ref(input logic [2:0] f3, input logic sub,
                                               input logic [XLEN-1:0] a,
                                               input logic [XLEN-1:0] b);
      case (f3)
         3'b000: return sub ? a - b : a + b;
         3'b010: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
         3'b011: return (a < b) ? 32'd1 : 32'd0;
         3'b100: return a ^ b;
         3'b110: return a | b;
         3'b111: return a & b;
         default: return '0;
      endcase
   endfunction

   // RV32I semantics of the kept instructions on the model registers
   function automatic ref_t execute_ref(input logic [XLEN-1:0] instr,
                                        input logic [XLEN-1:0] pc);
      ref_t res;
      logic [2:0] f3;
      logic [XLEN-1:0] a;
      logic [XLEN-1:0] b;
      logic [XLEN-1:0] imm_i;
      logic [XLEN-1:0] imm_b;
      logic [XLEN-1:0] imm_j;
      logic take;
      f3 = instr[14:12];
      a = model_regs[instr[19:15]];
      b = model_regs[instr[24:20]];
      imm_i = {{20{instr[31]}}, instr[31:20]};
      imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
      imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
      res.wb.rd = instr[11:7];
      res.wb.data = '0;
      res.next_pc = pc + 32'd4;
      // x0 writes retire silently
      res.wr = (instr[11:7] != 5'd0);
      take = 1'b0;
      case (instr[6:0])
         OPC_OP_IMM: res.wb.data = alu_ref(f3, 1'b0, a, imm_i);
         OPC_OP: res.wb.data = alu_ref(f3, instr[30], a, b);
         OPC_BRANCH: begin
            case (f3)
               3'b000: take = (a == b);
               3'b001: take = (a != b);
               3'b100: take = ($signed(a) < $signed(b));
               3'b101: take = ($signed(a) >= $signed(b));
               3'b110: take = (a < b);
               default: take = (a >= b);
            endcase
            res.wr = 1'b0;
            if (take) begin
               res.next_pc = pc + imm_b;
            end
         end
         OPC_JAL: begin
            res.wb.data = pc + 32'd4;
            res.next_pc = pc + imm_j;
         end
         default: res.wr = 1'b0;
      endcase
      return res;
   endfunction

   task automatic abort_run(input string why);
      $display("%s", why);
      $display("** FAIL **");
      $fatal(1, "simulation stopped at the first error");
   endtask

   task automatic check_adr(input logic [XLEN-1:0] got, input logic [XLEN-1:0] want);
      if (got !== want) begin
         abort_run($sformatf("CHECK FAILED at %0d ns: o_ibus_adr is %h, expected %h",
                             $time, got, want));
      end
   endtask

   task automatic check_wb(input wb_t got, input wb_t want);
      if (got !== want) begin
         abort_run($sformatf("CHECK FAILED at %0d ns: o_wb is x%0d=%h, expected x%0d=%h",
                             $time, got.rd, got.data, want.rd, want.data));
      end
   endtask

   // answers each fetch after 1 to 3 cycles with the program word
   task automatic respond_fetches();
      int n;
      int delay;
      logic [31:0] r;
      logic [XLEN-1:0] adr;
      forever begin
         n = 0;
         do begin
            @(posedge i_clk);
            n++;
            if (n > WAIT_LIMIT) begin
               abort_run("timeout: the DUT raised no fetch request");
            end
         end while (!o_ibus_cyc);
         r = next_rand();
         delay = 1 + int'(r[1:0]) % 3;
         repeat (delay) @(posedge i_clk);
         adr = o_ibus_adr;
         if (adr[1:0] != 2'b00 || adr >= XLEN'(PROG_LEN * 4)) begin
            abort_run($sformatf("fetch address %h lies outside the program", adr));
         end
         fetch_q.push_back(adr);
         i_ibus_ack <= 1'b1;
         i_ibus_rdt <= prog_mem[adr[9:2]];
         @(posedge i_clk);
         i_ibus_ack <= 1'b0;
         // the request drops in the cycle after the acknowledge
         n = 0;
         do begin
            @(posedge i_clk);
            n++;
            if (n > WAIT_LIMIT) begin
               abort_run("timeout: the fetch request stayed high after acknowledge");
            end
         end while (o_ibus_cyc);
      end
   endtask

   task automatic collect_wb();
      forever begin
         @(posedge i_clk);
         if (o_wb_valid) begin
            wb_q.push_back(o_wb);
         end
      end
   endtask

   // replays every fetched instruction on the model and compares the DUT with it
   task automatic compare_results();
      logic [XLEN-1:0] adr;
      logic [XLEN-1:0] model_pc;
      ref_t want;
      int n;
      bit parked;
      model_pc = RESET_PC;
      parked = 1'b0;
      forever begin
         n = 0;
         while (fetch_q.size() == 0) begin
            @(posedge i_clk);
            n++;
            if (n > WAIT_LIMIT) begin
               abort_run("timeout waiting for the next instruction fetch");
            end
         end
         adr = fetch_q.pop_front();
         // a record left over here came from an instruction that writes nothing
         if (wb_q.size() != 0) begin
            abort_run($sformatf("writeback to x%0d arrived with no write expected",
                                wb_q[0].rd));
         end
         check_adr(adr, model_pc);
         if (parked) begin
            break;
         end
         want = execute_ref(prog_mem[adr[9:2]], model_pc);
         if (want.wr) begin
            n = 0;
            while (wb_q.size() == 0) begin
               @(posedge i_clk);
               n++;
               if (n > WAIT_LIMIT) begin
                  abort_run("timeout waiting for a writeback record");
               end
            end
            check_wb(wb_q.pop_front(), want.wb);
            model_regs[want.wb.rd] = want.wb.data;
         end
         // the closing jump targets itself and its repeat fetch ends the run
         parked = (want.next_pc == model_pc);
         model_pc = want.next_pc;
      end
   endtask

   initial begin
      i_rst = 1'b1;
      i_ibus_ack = 1'b0;
      i_ibus_rdt = '0;
      lcg_state = 32'h6e54;
      model_regs = '{default: '0};
      build_program();
      repeat (3) @(posedge i_clk);
      i_rst <= 1'b0;
      fork
         respond_fetches();
         collect_wb();
      join_none
      compare_results();
      $display("** PASS **");
      $finish;
   end

endmodule
